//--- verilog/core_region_config.svh
`ifndef CORE_REGION_CONFIG_SVH
`define CORE_REGION_CONFIG_SVH

// DMA data path
`define CR_DATA_WIDTH 128
`define CR_STRB_WIDTH 16
`define CR_DMA_ADDR_WIDTH 26

// Local packet memory, indexed by byte address bits 11:4
`define CR_MEM_WORDS 256

// Broadcast region occupies the top 32 words
`define CR_BC_BASE 224

// Broadcast message: 11-bit offset, 4 strobes, 32 data bits
`define CR_MSG_WIDTH 47

`endif

//--- verilog/core_region_pkg.sv
`default_nettype none

`include "core_region_config.svh"

package core_region_pkg;

  // One DMA write beat
  typedef struct packed {
    logic [`CR_DATA_WIDTH-1:0]     data;
    logic [`CR_DMA_ADDR_WIDTH-1:0] addr;
    logic [`CR_STRB_WIDTH-1:0]     strb;
    logic                          last;
  } dma_wr_cmd_t;

  typedef struct packed {
    logic [`CR_DMA_ADDR_WIDTH-1:0] addr;
    logic                          last;
  } dma_rd_cmd_t;

  // 64-bit packet descriptor
  typedef struct packed {
    logic [3:0]  port;
    logic [3:0]  slot;
    logic [13:0] rsvd;
    logic [25:0] addr;
    logic [15:0] len;
  } desc_t;

  // Second flag sits above the descriptor, as on the wrapper side
  typedef struct packed {
    logic  second;
    desc_t desc;
  } out_desc_t;

  typedef struct packed {
    logic [10:0] addr;
    logic [3:0]  strb;
    logic [31:0] data;
  } bc_msg_t;

  typedef struct packed {
    logic [2:0] core_id;
    logic [3:0] dest_port;
    logic       enable;
  } core_cfg_t;

endpackage

`default_nettype wire

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type T = logic [7:0]
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  T s_data,
  input  wire  s_valid,
  input  wire  m_ready,
  output logic s_ready,
  output logic m_valid,
  output T     m_data
);

  logic skid_valid;
  T     skid_data;
  logic load_out;

  // Output register free to take a new beat
  assign load_out = m_ready || !m_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b0;
    end else begin
      if (load_out) begin
        m_valid    <= skid_valid || (s_valid && s_ready);
        skid_valid <= 1'b0;
        s_ready    <= 1'b1;
      end else if (s_valid && s_ready) begin
        // Downstream stalled, park the beat in the skid entry
        skid_valid <= 1'b1;
        s_ready    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (s_ready && !load_out) begin
      skid_data <= s_data;
    end
  end

  hold_while_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data)
  );

endmodule

`default_nettype wire

//--- verilog/core_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module core_status_regs (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [31:0]                   wrapper_status_data,
  input  wire [2:0]                    wrapper_status_addr,
  input  wire                          desc_done,
  input  wire                          bc_rx,
  input  wire                          dma_wr_done,
  output core_region_pkg::core_cfg_t   cfg,
  output logic [31:0]                  core_status_data,
  output logic [1:0]                   core_status_addr
);

  logic [31:0] desc_cnt;
  logic [31:0] bc_cnt;
  logic [31:0] wr_cnt;
  logic [1:0]  status_idx;

  //////////////////////////////////////////////////////////////////////
  // Wrapper side config writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else begin
      case (wrapper_status_addr)
        3'd1: cfg.core_id   <= wrapper_status_data[2:0];
        3'd2: cfg.dest_port <= wrapper_status_data[3:0];
        3'd3: cfg.enable    <= wrapper_status_data[0];
        // 0 is idle
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Event counters and rotating report
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desc_cnt   <= '0;
      bc_cnt     <= '0;
      wr_cnt     <= '0;
      status_idx <= '0;
    end else begin
      desc_cnt   <= desc_cnt + 32'(desc_done);
      bc_cnt     <= bc_cnt + 32'(bc_rx);
      wr_cnt     <= wr_cnt + 32'(dma_wr_done);
      status_idx <= status_idx + 2'd1;
    end
  end

  assign core_status_addr = status_idx;

  always_comb begin
    case (status_idx)
      2'd0:    core_status_data = desc_cnt;
      2'd1:    core_status_data = bc_cnt;
      2'd2:    core_status_data = wr_cnt;
      default: core_status_data = {23'd0, cfg.enable, cfg.dest_port, 1'b0, cfg.core_id};
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/pkt_mem_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module pkt_mem_core (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           core_rst,
  input  wire core_region_pkg::core_cfg_t   cfg,
  input  wire core_region_pkg::dma_wr_cmd_t wr_cmd,
  input  wire                           wr_valid,
  input  wire core_region_pkg::dma_rd_cmd_t rd_cmd,
  input  wire                           rd_valid,
  input  wire                           resp_ready,
  input  wire core_region_pkg::desc_t   in_desc,
  input  wire                           in_valid,
  input  wire                           out_ready,
  input  wire core_region_pkg::bc_msg_t bc_in,
  input  wire                           bc_in_valid,
  input  wire                           bc_out_ready,
  output logic                          wr_ready,
  output logic                          rd_ready,
  output logic [`CR_DATA_WIDTH-1:0]     resp_data,
  output logic                          resp_valid,
  output logic                          in_taken,
  output core_region_pkg::out_desc_t    out_desc,
  output logic                          out_valid,
  output core_region_pkg::bc_msg_t      bc_out,
  output logic                          bc_out_valid,
  output logic                          desc_done,
  output logic                          bc_rx,
  output logic                          dma_wr_done
);

  import core_region_pkg::*;

  localparam int MEM_AW = $clog2(`CR_MEM_WORDS);

  logic [`CR_DATA_WIDTH-1:0] mem [`CR_MEM_WORDS];

  logic              core_rst_n;
  logic [MEM_AW-1:0] wr_idx;
  logic [MEM_AW-1:0] bc_idx;
  logic [1:0]        bc_lane;
  logic [`CR_DATA_WIDTH-1:0] desc_word;
  logic              desc_accept;
  desc_t             first_desc;
  desc_t             upper_desc;
  bc_msg_t           bc_next;

  assign core_rst_n = rst_n && !core_rst;

  //////////////////////////////////////////////////////////////////////
  // Memory writes from DMA and broadcast in
  //////////////////////////////////////////////////////////////////////

  assign wr_idx   = wr_cmd.addr[MEM_AW+3:4];
  assign bc_idx   = MEM_AW'(`CR_BC_BASE) + MEM_AW'(bc_in.addr[9:4]);
  assign bc_lane  = bc_in.addr[3:2];
  assign wr_ready = 1'b1;

  // Broadcast lane wins a same-word clash
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      for (int i = 0; i < `CR_STRB_WIDTH; i++) begin
        if (wr_cmd.strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= wr_cmd.data[i*8 +: 8];
        end
      end
    end
    if (bc_in_valid) begin
      for (int j = 0; j < 4; j++) begin
        if (bc_in.strb[j]) begin
          mem[bc_idx][bc_lane*32 + j*8 +: 8] <= bc_in.data[j*8 +: 8];
        end
      end
    end
  end

  assign dma_wr_done = wr_valid;
  assign bc_rx       = bc_in_valid;

  //////////////////////////////////////////////////////////////////////
  // DMA read response
  //////////////////////////////////////////////////////////////////////

  assign rd_ready = !resp_valid || resp_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_ready) begin
      resp_valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid && rd_ready) begin
      resp_data <= mem[rd_cmd.addr[MEM_AW+3:4]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor processing
  //////////////////////////////////////////////////////////////////////

  // Wait until both the out beats and the message have left
  assign in_taken    = cfg.enable && !out_valid && !bc_out_valid;
  assign desc_accept = in_valid && in_taken;
  assign desc_word   = mem[in_desc.addr[MEM_AW+3:4]];

  always_comb begin
    first_desc      = in_desc;
    first_desc.port = cfg.dest_port;
    first_desc.len  = desc_word[15:0];
    bc_next.addr    = {3'b000, in_desc.slot, 4'b0000};
    bc_next.strb    = 4'hf;
    bc_next.data    = {cfg.core_id, in_desc[28:0]};
  end

  always_ff @(posedge clk or negedge core_rst_n) begin
    if (!core_rst_n) begin
      out_valid    <= 1'b0;
      bc_out_valid <= 1'b0;
    end else begin
      if (desc_accept) begin
        out_valid    <= 1'b1;
        bc_out_valid <= 1'b1;
      end else begin
        if (out_valid && out_ready && out_desc.second) begin
          out_valid <= 1'b0;
        end
        if (bc_out_valid && bc_out_ready) begin
          bc_out_valid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (desc_accept) begin
      out_desc   <= '{second: 1'b0, desc: first_desc};
      upper_desc <= desc_word[127:64];
      bc_out     <= bc_next;
    end else if (out_valid && out_ready && !out_desc.second) begin
      out_desc <= '{second: 1'b1, desc: upper_desc};
    end
  end

  assign desc_done = out_valid && out_ready && out_desc.second;

  // Config comes from the status block
  no_out_when_disabled: assert property (
    @(posedge clk) disable iff (!core_rst_n)
    !cfg.enable && !out_valid |=> !out_valid
  );

endmodule

`default_nettype wire

//--- verilog/core_region.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module core_region (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              core_reset,

  // DMA
  input  wire                              dma_cmd_wr_en,
  input  wire [`CR_DMA_ADDR_WIDTH-1:0]     dma_cmd_wr_addr,
  input  wire [`CR_DATA_WIDTH-1:0]         dma_cmd_wr_data,
  input  wire [`CR_STRB_WIDTH-1:0]         dma_cmd_wr_strb,
  input  wire                              dma_cmd_wr_last,
  output logic                             dma_cmd_wr_ready,
  input  wire                              dma_cmd_rd_en,
  input  wire [`CR_DMA_ADDR_WIDTH-1:0]     dma_cmd_rd_addr,
  input  wire                              dma_cmd_rd_last,
  output logic                             dma_cmd_rd_ready,
  output logic                             dma_rd_resp_valid,
  output logic [`CR_DATA_WIDTH-1:0]        dma_rd_resp_data,
  input  wire                              dma_rd_resp_ready,

  // Descriptors
  input  wire [63:0]                       in_desc,
  input  wire                              in_desc_valid,
  output logic                             in_desc_taken,
  output logic [63:0]                      out_desc,
  output logic                             out_desc_2nd,
  output logic                             out_desc_valid,
  input  wire                              out_desc_ready,

  // Broadcast messages
  input  wire [`CR_MSG_WIDTH-1:0]          bc_msg_in,
  input  wire                              bc_msg_in_valid,
  output logic [`CR_MSG_WIDTH-1:0]         bc_msg_out,
  output logic                             bc_msg_out_valid,
  input  wire                              bc_msg_out_ready,

  // Status channel
  input  wire [31:0]                       wrapper_status_data,
  input  wire [2:0]                        wrapper_status_addr,
  output logic [31:0]                      core_status_data,
  output logic [1:0]                       core_status_addr
);

  import core_region_pkg::*;

  logic rst_n_r;
  logic core_reset_r;
  logic core_rst_n;

  dma_wr_cmd_t wr_cmd_in, wr_cmd_r;
  logic        wr_valid_r, wr_ready_r;
  dma_rd_cmd_t rd_cmd_r;
  logic        rd_valid_r, rd_ready_r;
  logic [`CR_DATA_WIDTH-1:0] resp_data_n;
  logic        resp_valid_n, resp_ready_n;
  desc_t       in_desc_r;
  logic        in_valid_r, in_taken_r;
  out_desc_t   out_desc_n, out_desc_r;
  logic        out_valid_n, out_ready_n;
  bc_msg_t     bc_in_r, bc_out_n;
  logic        bc_in_valid_r, bc_out_valid_n, bc_out_ready_n;

  logic [31:0] wrapper_status_data_r;
  logic [2:0]  wrapper_status_addr_r;
  logic [31:0] core_status_data_n;
  logic [1:0]  core_status_addr_n;
  core_cfg_t   cfg;
  logic        desc_done, bc_rx, dma_wr_done;

  //////////////////////////////////////////////////////////////////////
  // Boundary resets and status registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_n_r               <= 1'b0;
      core_reset_r          <= 1'b0;
      wrapper_status_addr_r <= '0;
    end else begin
      rst_n_r               <= 1'b1;
      core_reset_r          <= core_reset;
      wrapper_status_addr_r <= wrapper_status_addr;
    end
  end

  // Core side paths also clear on core_reset
  assign core_rst_n = rst_n_r && !core_reset_r;

  always_ff @(posedge clk) begin
    wrapper_status_data_r <= wrapper_status_data;
    core_status_data      <= core_status_data_n;
    core_status_addr      <= core_status_addr_n;
  end

  //////////////////////////////////////////////////////////////////////
  // Channel pipe stages
  //////////////////////////////////////////////////////////////////////

  assign wr_cmd_in = '{data: dma_cmd_wr_data, addr: dma_cmd_wr_addr,
                       strb: dma_cmd_wr_strb, last: dma_cmd_wr_last};

  pipe_reg #(.T(dma_wr_cmd_t)) i_dma_wr_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(wr_cmd_in), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_cmd_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.T(dma_rd_cmd_t)) i_dma_rd_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data({dma_cmd_rd_addr, dma_cmd_rd_last}), .s_valid(dma_cmd_rd_en),
    .s_ready(dma_cmd_rd_ready),
    .m_data(rd_cmd_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.T(logic [`CR_DATA_WIDTH-1:0])) i_rd_resp_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid), .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.T(desc_t)) i_in_desc_reg (
    .clk(clk), .rst_n(core_rst_n),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_valid_r), .m_ready(in_taken_r)
  );

  pipe_reg #(.T(out_desc_t)) i_out_desc_reg (
    .clk(clk), .rst_n(core_rst_n),
    .s_data(out_desc_n), .s_valid(out_valid_n), .s_ready(out_ready_n),
    .m_data(out_desc_r), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  assign out_desc     = out_desc_r.desc;
  assign out_desc_2nd = out_desc_r.second;

  // Broadcast in is never back-pressured
  pipe_reg #(.T(bc_msg_t)) i_bc_in_reg (
    .clk(clk), .rst_n(core_rst_n),
    .s_data(bc_msg_in), .s_valid(bc_msg_in_valid), .s_ready(),
    .m_data(bc_in_r), .m_valid(bc_in_valid_r), .m_ready(1'b1)
  );

  pipe_reg #(.T(bc_msg_t)) i_bc_out_reg (
    .clk(clk), .rst_n(rst_n_r),
    .s_data(bc_out_n), .s_valid(bc_out_valid_n), .s_ready(bc_out_ready_n),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Core and status block
  //////////////////////////////////////////////////////////////////////

  pkt_mem_core i_core (
    .clk(clk), .rst_n(rst_n_r), .core_rst(core_reset_r), .cfg(cfg),
    .wr_cmd(wr_cmd_r), .wr_valid(wr_valid_r), .wr_ready(wr_ready_r),
    .rd_cmd(rd_cmd_r), .rd_valid(rd_valid_r), .rd_ready(rd_ready_r),
    .resp_data(resp_data_n), .resp_valid(resp_valid_n), .resp_ready(resp_ready_n),
    .in_desc(in_desc_r), .in_valid(in_valid_r), .in_taken(in_taken_r),
    .out_desc(out_desc_n), .out_valid(out_valid_n), .out_ready(out_ready_n),
    .bc_in(bc_in_r), .bc_in_valid(bc_in_valid_r),
    .bc_out(bc_out_n), .bc_out_valid(bc_out_valid_n), .bc_out_ready(bc_out_ready_n),
    .desc_done(desc_done), .bc_rx(bc_rx), .dma_wr_done(dma_wr_done)
  );

  core_status_regs i_status (
    .clk(clk), .rst_n(rst_n_r),
    .wrapper_status_data(wrapper_status_data_r),
    .wrapper_status_addr(wrapper_status_addr_r),
    .desc_done(desc_done), .bc_rx(bc_rx), .dma_wr_done(dma_wr_done),
    .cfg(cfg),
    .core_status_data(core_status_data_n),
    .core_status_addr(core_status_addr_n)
  );

endmodule

`default_nettype wire

//--- bench/core_region_tb_checks.svh
`ifndef CORE_REGION_TB_CHECKS_SVH
`define CORE_REGION_TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

task automatic model_dma_write(input logic [`CR_DMA_ADDR_WIDTH-1:0] addr,
                               input logic [`CR_DATA_WIDTH-1:0] data,
                               input logic [`CR_STRB_WIDTH-1:0] strb);
  for (int i = 0; i < `CR_STRB_WIDTH; i++) begin
    if (strb[i]) begin
      mem_model[addr[11:4]][i*8 +: 8] = data[i*8 +: 8];
    end
  end
endtask

// Broadcast offset picks a word above the base and a 32-bit lane in it
task automatic model_bc_write(input logic [10:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
  logic [7:0] word;
  int         lane;
  word = 8'(`CR_BC_BASE) + 8'(addr[9:4]);
  lane = int'(addr[3:2]);
  for (int j = 0; j < 4; j++) begin
    if (strb[j]) begin
      mem_model[word][lane*32 + j*8 +: 8] = data[j*8 +: 8];
    end
  end
endtask

function automatic out_desc_t first_out_desc(input desc_t d, input logic [127:0] word,
                                             input core_cfg_t cfg);
  out_desc_t r;
  r.second    = 1'b0;
  r.desc      = d;
  r.desc.port = cfg.dest_port;
  r.desc.len  = word[15:0];
  return r;
endfunction

function automatic out_desc_t second_out_desc(input logic [127:0] word);
  out_desc_t r;
  r.second = 1'b1;
  r.desc   = desc_t'(word[127:64]);
  return r;
endfunction

function automatic bc_msg_t expected_msg(input desc_t d, input core_cfg_t cfg);
  bc_msg_t     m;
  logic [63:0] raw;
  raw    = d;
  m.addr = 11'(d.slot) * 11'd16;
  m.strb = 4'hf;
  m.data = {cfg.core_id, raw[28:0]};
  return m;
endfunction

// Config word fields: core_id 2:0, dest_port 7:4, enable 8
function automatic logic [31:0] cfg_status_word(input core_cfg_t cfg);
  logic [31:0] w;
  w      = '0;
  w[2:0] = cfg.core_id;
  w[7:4] = cfg.dest_port;
  w[8]   = cfg.enable;
  return w;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_resp(input logic [`CR_DATA_WIDTH-1:0] got,
                          input logic [`CR_DATA_WIDTH-1:0] exp);
  if (got !== exp) begin
    report_failure($sformatf("MISMATCH dma_rd_resp_data got %h exp %h", got, exp));
  end
endtask

task automatic check_desc(input out_desc_t got, input out_desc_t exp);
  if (got !== exp) begin
    report_failure($sformatf("MISMATCH out_desc got %h exp %h", got, exp));
  end
endtask

task automatic check_msg(input bc_msg_t got, input bc_msg_t exp);
  if (got !== exp) begin
    report_failure($sformatf("MISMATCH bc_msg_out got %h exp %h", got, exp));
  end
endtask

task automatic check_status(input logic [31:0] got_data, input logic [1:0] got_addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_addr);
  if (got_addr !== exp_addr) begin
    report_failure($sformatf("MISMATCH core_status_addr got %h exp %h", got_addr, exp_addr));
  end
  if (got_data !== exp_data) begin
    report_failure($sformatf("MISMATCH core_status_data got %h exp %h", got_data, exp_data));
  end
endtask

`endif

//--- bench/core_region_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module core_region_tb;

  import core_region_pkg::*;

  localparam int NUM_ROWS       = 30;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

  localparam logic [3:0] OP_WR   = 4'd0;
  localparam logic [3:0] OP_RD   = 4'd1;
  localparam logic [3:0] OP_CFG  = 4'd2;
  localparam logic [3:0] OP_BC   = 4'd3;
  localparam logic [3:0] OP_DESC = 4'd4;
  localparam logic [3:0] OP_STAT = 4'd5;
  localparam logic [3:0] OP_CRST = 4'd6;
  localparam logic [3:0] OP_WAIT = 4'd7;

  typedef struct packed {
    logic [3:0]                    kind;
    logic [`CR_DMA_ADDR_WIDTH-1:0] addr;
    logic [`CR_DATA_WIDTH-1:0]     data;
    logic [`CR_STRB_WIDTH-1:0]     strb;
    desc_t                         desc;
  } row_t;

  logic                          clk;
  logic                          rst_n;
  logic                          core_reset;
  logic                          dma_cmd_wr_en;
  logic [`CR_DMA_ADDR_WIDTH-1:0] dma_cmd_wr_addr;
  logic [`CR_DATA_WIDTH-1:0]     dma_cmd_wr_data;
  logic [`CR_STRB_WIDTH-1:0]     dma_cmd_wr_strb;
  logic                          dma_cmd_wr_last;
  logic                          dma_cmd_wr_ready;
  logic                          dma_cmd_rd_en;
  logic [`CR_DMA_ADDR_WIDTH-1:0] dma_cmd_rd_addr;
  logic                          dma_cmd_rd_last;
  logic                          dma_cmd_rd_ready;
  logic                          dma_rd_resp_valid;
  logic [`CR_DATA_WIDTH-1:0]     dma_rd_resp_data;
  logic                          dma_rd_resp_ready;
  logic [63:0]                   in_desc;
  logic                          in_desc_valid;
  logic                          in_desc_taken;
  logic [63:0]                   out_desc;
  logic                          out_desc_2nd;
  logic                          out_desc_valid;
  logic                          out_desc_ready;
  logic [`CR_MSG_WIDTH-1:0]      bc_msg_in;
  logic                          bc_msg_in_valid;
  logic [`CR_MSG_WIDTH-1:0]      bc_msg_out;
  logic                          bc_msg_out_valid;
  logic                          bc_msg_out_ready;
  logic [31:0]                   wrapper_status_data;
  logic [2:0]                    wrapper_status_addr;
  logic [31:0]                   core_status_data;
  logic [1:0]                    core_status_addr;

  // Model state and scoreboard
  logic [`CR_DATA_WIDTH-1:0] mem_model [`CR_MEM_WORDS];
  core_cfg_t                 cfg_model;
  logic [`CR_DATA_WIDTH-1:0] resp_q [$];
  out_desc_t                 desc_q [$];
  bc_msg_t                   msg_q [$];
  desc_t                     held_desc;
  logic                      held_valid;
  int                        n_desc;
  int                        n_bc;
  int                        n_wr;
  int                        cycle_cnt;
  logic [15:0]               lfsr;
  row_t                      rows [NUM_ROWS];

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

`include "core_region_tb_checks.svh"

  core_region i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Ready drops and output monitors
  //////////////////////////////////////////////////////////////////////

  // Transfer seen here completes on the following rising edge
  always @(negedge clk) begin
    lfsr = lfsr_step(lfsr);
    dma_rd_resp_ready = lfsr[0];
    lfsr = lfsr_step(lfsr);
    out_desc_ready = lfsr[0];
    lfsr = lfsr_step(lfsr);
    bc_msg_out_ready = lfsr[0];
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      if (resp_q.size() == 0) begin
        report_failure("Read response arrived with no read outstanding");
      end
      check_resp(dma_rd_resp_data, resp_q.pop_front());
    end
    if (out_desc_valid && out_desc_ready) begin
      if (desc_q.size() == 0) begin
        report_failure("Output descriptor arrived with none expected");
      end
      check_desc(out_desc_t'({out_desc_2nd, out_desc}), desc_q.pop_front());
    end
    if (bc_msg_out_valid && bc_msg_out_ready) begin
      if (msg_q.size() == 0) begin
        report_failure("Broadcast message arrived with none expected");
      end
      check_msg(bc_msg_t'(bc_msg_out), msg_q.pop_front());
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      report_failure($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Row handling
  //////////////////////////////////////////////////////////////////////

  task automatic drain_queues();
    while (resp_q.size() != 0 || desc_q.size() != 0 || msg_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic push_desc_expect(input desc_t d);
    logic [`CR_DATA_WIDTH-1:0] word;
    word = mem_model[d.addr[11:4]];
    desc_q.push_back(first_out_desc(d, word, cfg_model));
    desc_q.push_back(second_out_desc(word));
    msg_q.push_back(expected_msg(d, cfg_model));
    n_desc++;
  endtask

  // Status address must step 0,1,2,3 on consecutive cycles
  task automatic check_counters();
    logic [31:0] exp_val;
    drain_queues();
    repeat (6) @(negedge clk);
    while (core_status_addr != 2'd0) @(negedge clk);
    for (int k = 0; k < 4; k++) begin
      case (k)
        0:       exp_val = n_desc;
        1:       exp_val = n_bc;
        2:       exp_val = n_wr;
        default: exp_val = cfg_status_word(cfg_model);
      endcase
      check_status(core_status_data, core_status_addr, exp_val, 2'(k));
      @(negedge clk);
    end
  endtask

  task automatic apply_row(input row_t r);
    bc_msg_t msg;
    case (r.kind)
      OP_WR: begin
        dma_cmd_wr_addr = r.addr;
        dma_cmd_wr_data = r.data;
        dma_cmd_wr_strb = r.strb;
        dma_cmd_wr_last = 1'b1;
        dma_cmd_wr_en   = 1'b1;
        while (!dma_cmd_wr_ready) @(negedge clk);
        @(negedge clk);
        dma_cmd_wr_en = 1'b0;
        model_dma_write(r.addr, r.data, r.strb);
        n_wr++;
      end
      OP_RD: begin
        dma_cmd_rd_addr = r.addr;
        dma_cmd_rd_last = 1'b1;
        dma_cmd_rd_en   = 1'b1;
        while (!dma_cmd_rd_ready) @(negedge clk);
        @(negedge clk);
        dma_cmd_rd_en = 1'b0;
        resp_q.push_back(mem_model[r.addr[11:4]]);
      end
      OP_CFG: begin
        drain_queues();
        wrapper_status_addr = r.addr[2:0];
        wrapper_status_data = r.data[31:0];
        @(negedge clk);
        wrapper_status_addr = 3'd0;
        case (r.addr[2:0])
          3'd1:    cfg_model.core_id   = r.data[2:0];
          3'd2:    cfg_model.dest_port = r.data[3:0];
          3'd3:    cfg_model.enable    = r.data[0];
          default: ;
        endcase
        // A held descriptor goes through once the core is enabled
        if (cfg_model.enable && held_valid) begin
          push_desc_expect(held_desc);
          held_valid = 1'b0;
        end
        repeat (2) @(negedge clk);
      end
      OP_BC: begin
        msg.addr        = r.addr[10:0];
        msg.strb        = r.strb[3:0];
        msg.data        = r.data[31:0];
        bc_msg_in       = msg;
        bc_msg_in_valid = 1'b1;
        @(negedge clk);
        bc_msg_in_valid = 1'b0;
        model_bc_write(msg.addr, msg.strb, msg.data);
        n_bc++;
      end
      OP_DESC: begin
        in_desc       = r.desc;
        in_desc_valid = 1'b1;
        while (!in_desc_taken) @(negedge clk);
        @(negedge clk);
        in_desc_valid = 1'b0;
        if (cfg_model.enable) begin
          push_desc_expect(r.desc);
        end else begin
          held_desc  = r.desc;
          held_valid = 1'b1;
        end
      end
      OP_STAT: check_counters();
      OP_CRST: begin
        drain_queues();
        repeat (4) @(negedge clk);
        core_reset = 1'b1;
        repeat (3) @(negedge clk);
        core_reset = 1'b0;
        // Core reset drops a descriptor held at the boundary
        held_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (out_desc_valid || bc_msg_out_valid || !in_desc_taken) begin
          report_failure("Descriptor path is not idle after core reset");
        end
      end
      default: begin
        repeat (10) begin
          @(negedge clk);
          if (out_desc_valid || bc_msg_out_valid) begin
            report_failure("Core produced output while it was disabled");
          end
        end
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n               = 1'b0;
    core_reset          = 1'b0;
    dma_cmd_wr_en       = 1'b0;
    dma_cmd_wr_addr     = '0;
    dma_cmd_wr_data     = '0;
    dma_cmd_wr_strb     = '0;
    dma_cmd_wr_last     = 1'b0;
    dma_cmd_rd_en       = 1'b0;
    dma_cmd_rd_addr     = '0;
    dma_cmd_rd_last     = 1'b0;
    dma_rd_resp_ready   = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    out_desc_ready      = 1'b0;
    bc_msg_in           = '0;
    bc_msg_in_valid     = 1'b0;
    bc_msg_out_ready    = 1'b0;
    wrapper_status_data = '0;
    wrapper_status_addr = '0;
    cfg_model           = '0;
    held_desc           = '0;
    held_valid          = 1'b0;
    n_desc              = 0;
    n_bc                = 0;
    n_wr                = 0;
    cycle_cnt           = 0;
    lfsr                = 16'd29;

    // kind, addr, data, strb, descriptor
    rows = '{
      '{OP_WR,   26'h0010, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 16'hffff, 64'h0},
      '{OP_WR,   26'h0010, {4{32'hdeadbeef}}, 16'h00f0, 64'h0},
      '{OP_WR,   26'h0020, 128'h11112222_33334444_55556666_77778888, 16'hffff, 64'h0},
      '{OP_WR,   26'h0020, {4{32'h5a5aa5a5}}, 16'ha5a5, 64'h0},
      '{OP_WR,   26'h4030, 128'h01234567_89abcdef_fedcba98_76543210, 16'hffff, 64'h0},
      '{OP_WR,   26'h0e10, 128'ha0a1a2a3_b0b1b2b3_c0c1c2c3_d0d1d2d3, 16'hffff, 64'h0},
      '{OP_RD,   26'h0010, 128'h0, 16'h0, 64'h0},
      '{OP_RD,   26'h0020, 128'h0, 16'h0, 64'h0},
      '{OP_RD,   26'h4030, 128'h0, 16'h0, 64'h0},
      '{OP_RD,   26'h0030, 128'h0, 16'h0, 64'h0},
      '{OP_CFG,  26'h1, 128'h5, 16'h0, 64'h0},
      '{OP_CFG,  26'h2, 128'h9, 16'h0, 64'h0},
      '{OP_STAT, 26'h0, 128'h0, 16'h0, 64'h0},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'h0, 4'h3, 14'h0, 26'h0010, 16'h0040}},
      '{OP_WAIT, 26'h0, 128'h0, 16'h0, 64'h0},
      '{OP_CFG,  26'h3, 128'h1, 16'h0, 64'h0},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'h0, 4'h7, 14'h1234, 26'h0020, 16'h0080}},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'hc, 4'hf, 14'h0, 26'h4030, 16'h0100}},
      '{OP_BC,   26'h014, 128'hcafef00d, 16'hf, 64'h0},
      '{OP_BC,   26'h018, 128'h12345678, 16'h5, 64'h0},
      '{OP_RD,   26'h0e10, 128'h0, 16'h0, 64'h0},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'h0, 4'h2, 14'h3fff, 26'h0e10, 16'h0020}},
      '{OP_STAT, 26'h0, 128'h0, 16'h0, 64'h0},
      '{OP_CFG,  26'h3, 128'h0, 16'h0, 64'h0},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'h0, 4'h6, 14'h0, 26'h0020, 16'h0008}},
      '{OP_CRST, 26'h0, 128'h0, 16'h0, 64'h0},
      '{OP_CFG,  26'h3, 128'h1, 16'h0, 64'h0},
      '{OP_RD,   26'h0020, 128'h0, 16'h0, 64'h0},
      '{OP_DESC, 26'h0, 128'h0, 16'h0, {4'h5, 4'h1, 14'h0, 26'h0010, 16'h0010}},
      '{OP_STAT, 26'h0, 128'h0, 16'h0, 64'h0}
    };

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end

    drain_queues();
    repeat (4) @(negedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- core_region.f
+incdir+verilog
+incdir+bench
verilog/core_region_pkg.sv
verilog/pipe_reg.sv
verilog/core_status_regs.sv
verilog/pkt_mem_core.sv
verilog/core_region.sv
bench/core_region_tb.sv
